// File: src/mem_pkg.sv
package mem_pkg;

  ////////////////////////////////
  // Sizes
  ////////////////////////////////

  localparam int data_width = 16;
  localparam int num_lbank = 4;
  localparam int num_pbank = num_lbank + 1; // One spare bank per row.
  localparam int num_row = 16;
  localparam int read_latency = 2; // Cycles from read to rd_vld.

  localparam int row_bits = $clog2(num_row);
  localparam int lbank_bits = $clog2(num_lbank);
  localparam int pbank_bits = $clog2(num_pbank);
  localparam int addr_bits = lbank_bits + row_bits;

  ////////////////////////////////
  // Vector types
  ////////////////////////////////

  typedef logic [data_width-1:0] data_t;
  typedef logic [addr_bits-1:0] addr_t; // {logical bank, row}.
  typedef logic [row_bits-1:0] row_t;
  typedef logic [lbank_bits-1:0] lbank_t;
  typedef logic [pbank_bits-1:0] pbank_t;
  typedef logic [num_pbank-1:0] pbank_vec_t;

endpackage

// File: src/bank_ram.sv
`timescale 1ns/1ps

// One physical bank with a write port and a read port.
module bank_ram import mem_pkg::*; (
  input  logic  clk,
  input  logic  we,
  input  row_t  wr_row,
  input  data_t wr_data,
  input  logic  re,
  input  row_t  rd_row,
  output data_t rd_data
);

  data_t mem [num_row];

  ////////////////////////////////
  // Write port
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end
  end

  ////////////////////////////////
  // Read port
  ////////////////////////////////

  // A read to a row written at the same edge sees the old word.
  always_ff @(posedge clk) begin
    if (re) begin
      rd_data <= mem[rd_row];
    end
  end

endmodule

// File: src/bank_map.sv
`timescale 1ns/1ps

// Per-row map from logical bank to physical bank, plus the free bank.
module bank_map import mem_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  // Lookup keys.
  input  row_t   wr_row0,
  input  lbank_t wr_lbank0,
  input  row_t   wr_row1,
  input  lbank_t wr_lbank1,
  input  row_t   rd_row,
  input  lbank_t rd_lbank,
  // Update after a write conflict.
  input  logic   upd,
  input  row_t   upd_row,
  input  lbank_t upd_lbank,
  input  pbank_t upd_pbank,
  // Lookup results.
  output pbank_t wr_pbank0,
  output pbank_t wr_pbank1,
  output pbank_t rd_pbank,
  output pbank_t free_pbank1
);

  ////////////////////////////////
  // Map table
  ////////////////////////////////

  pbank_t home_tbl [num_row][num_lbank]; // Home bank of each logical bank.
  pbank_t free_tbl [num_row]; // Unused bank of each row.

  pbank_t old_home;

  function automatic pbank_t home_of(row_t row, lbank_t lbank);
    return home_tbl[row][lbank];
  endfunction

  ////////////////////////////////
  // Lookups
  ////////////////////////////////

  assign wr_pbank0 = home_of(wr_row0, wr_lbank0);
  assign wr_pbank1 = home_of(wr_row1, wr_lbank1);
  assign rd_pbank = home_of(rd_row, rd_lbank);
  assign free_pbank1 = free_tbl[wr_row1];

  // The bank given up by the moving logical bank.
  assign old_home = home_of(upd_row, upd_lbank);

  ////////////////////////////////
  // Update
  ////////////////////////////////

  // Identity map out of reset, the last bank spare in every row.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < num_row; r++) begin
        for (int l = 0; l < num_lbank; l++) begin
          home_tbl[r][l] <= pbank_t'(l);
        end
        free_tbl[r] <= pbank_t'(num_lbank);
      end
    end else if (upd) begin
      home_tbl[upd_row][upd_lbank] <= upd_pbank;
      free_tbl[upd_row] <= old_home; // Old home becomes the spare.
    end
  end

endmodule

// File: src/write_steer.sv
`timescale 1ns/1ps

// Steers the two write ports onto the physical banks.
module write_steer import mem_pkg::*; (
  input  logic [1:0] write,
  input  row_t       wr_row0,
  input  lbank_t     wr_lbank0,
  input  row_t       wr_row1,
  input  lbank_t     wr_lbank1,
  input  data_t      din0,
  input  data_t      din1,
  input  pbank_t     wr_pbank0,
  input  pbank_t     wr_pbank1,
  input  pbank_t     free_pbank1,
  // Bank write ports.
  output pbank_vec_t bank_we,
  output row_t       bank_wr_row [num_pbank],
  output data_t      bank_wr_data [num_pbank],
  // Map update.
  output logic       upd,
  output row_t       upd_row,
  output lbank_t     upd_lbank,
  output pbank_t     upd_pbank
);

  logic   same_adr;
  logic   we0;
  logic   we1;
  logic   conflict;
  pbank_t pbank1;

  ////////////////////////////////
  // Conflict check
  ////////////////////////////////

  assign same_adr = write[0] && write[1] && (wr_row0 == wr_row1) && (wr_lbank0 == wr_lbank1);
  assign we0 = write[0] && !same_adr; // Port 1 wins on the same address.
  assign we1 = write[1];

  assign conflict = we0 && we1 && (wr_pbank0 == wr_pbank1);

  // Port 0 sits in a mapped bank of row 1 here, so the spare is clear.
  assign pbank1 = conflict ? free_pbank1 : wr_pbank1;

  assign upd = conflict;
  assign upd_row = wr_row1;
  assign upd_lbank = wr_lbank1;
  assign upd_pbank = free_pbank1;

  ////////////////////////////////
  // Bank routing
  ////////////////////////////////

  always_comb begin
    bank_we = '0;
    for (int i = 0; i < num_pbank; i++) begin
      if (we1 && pbank1 == pbank_t'(i)) begin
        bank_we[i] = 1'b1;
        bank_wr_row[i] = wr_row1;
        bank_wr_data[i] = din1;
      end else begin
        bank_we[i] = we0 && (wr_pbank0 == pbank_t'(i));
        bank_wr_row[i] = wr_row0;
        bank_wr_data[i] = din0;
      end
    end
  end

endmodule

// File: src/read_path.sv
`timescale 1ns/1ps

// Two-stage read: bank access, then output select.
module read_path import mem_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       read,
  input  row_t       rd_row,
  input  pbank_t     rd_pbank,
  input  data_t      bank_rd_data [num_pbank],
  output pbank_vec_t bank_re,
  output row_t       bank_rd_row,
  output logic       rd_vld,
  output data_t      rd_dout
);

  logic   vld_s1;
  pbank_t pbank_s1;
  data_t  sel_data;

  // Only the addressed bank is enabled.
  always_comb begin
    for (int i = 0; i < num_pbank; i++) begin
      bank_re[i] = read && (rd_pbank == pbank_t'(i));
    end
  end

  assign bank_rd_row = rd_row;

  ////////////////////////////////
  // Stage 1
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_s1 <= 1'b0;
    end else begin
      vld_s1 <= read;
    end
  end

  always_ff @(posedge clk) begin
    pbank_s1 <= rd_pbank; // Bank to pick next cycle.
  end

  ////////////////////////////////
  // Stage 2
  ////////////////////////////////

  always_comb begin
    sel_data = bank_rd_data[0];
    for (int i = 1; i < num_pbank; i++) begin
      if (pbank_s1 == pbank_t'(i)) begin
        sel_data = bank_rd_data[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= vld_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_s1) begin
      rd_dout <= sel_data;
    end
  end

endmodule

// File: src/mem_1r2w_top.sv
`timescale 1ns/1ps

// 1R2W memory from five 1R1W banks with a per-row spare bank.
module mem_1r2w_top import mem_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  // Write ports.
  input  logic [1:0] write,
  input  addr_t      wr_adr0,
  input  addr_t      wr_adr1,
  input  data_t      din0,
  input  data_t      din1,
  // Read port.
  input  logic       read,
  input  addr_t      rd_adr,
  output logic       rd_vld,
  output data_t      rd_dout
);

  ////////////////////////////////
  // Wires
  ////////////////////////////////

  // Map lookups.
  pbank_t wr_pbank0;
  pbank_t wr_pbank1;
  pbank_t rd_pbank;
  pbank_t free_pbank1;

  // Map update.
  logic   upd;
  row_t   upd_row;
  lbank_t upd_lbank;
  pbank_t upd_pbank;

  // Bank side.
  pbank_vec_t bank_we;
  row_t       bank_wr_row [num_pbank];
  data_t      bank_wr_data [num_pbank];
  pbank_vec_t bank_re;
  row_t       bank_rd_row;
  data_t      bank_rd_data [num_pbank];

  ////////////////////////////////
  // Control
  ////////////////////////////////

  bank_map map_i (
    .clk         (clk),
    .reset       (reset),
    .wr_row0     (wr_adr0[row_bits-1:0]),
    .wr_lbank0   (wr_adr0[addr_bits-1:row_bits]),
    .wr_row1     (wr_adr1[row_bits-1:0]),
    .wr_lbank1   (wr_adr1[addr_bits-1:row_bits]),
    .rd_row      (rd_adr[row_bits-1:0]),
    .rd_lbank    (rd_adr[addr_bits-1:row_bits]),
    .upd         (upd),
    .upd_row     (upd_row),
    .upd_lbank   (upd_lbank),
    .upd_pbank   (upd_pbank),
    .wr_pbank0   (wr_pbank0),
    .wr_pbank1   (wr_pbank1),
    .rd_pbank    (rd_pbank),
    .free_pbank1 (free_pbank1)
  );

  write_steer steer_i (
    .write        (write),
    .wr_row0      (wr_adr0[row_bits-1:0]),
    .wr_lbank0    (wr_adr0[addr_bits-1:row_bits]),
    .wr_row1      (wr_adr1[row_bits-1:0]),
    .wr_lbank1    (wr_adr1[addr_bits-1:row_bits]),
    .din0         (din0),
    .din1         (din1),
    .wr_pbank0    (wr_pbank0),
    .wr_pbank1    (wr_pbank1),
    .free_pbank1  (free_pbank1),
    .bank_we      (bank_we),
    .bank_wr_row  (bank_wr_row),
    .bank_wr_data (bank_wr_data),
    .upd          (upd),
    .upd_row      (upd_row),
    .upd_lbank    (upd_lbank),
    .upd_pbank    (upd_pbank)
  );

  ////////////////////////////////
  // Banks and read
  ////////////////////////////////

  for (genvar i = 0; i < num_pbank; i++) begin : g_bank
    bank_ram ram_i (
      .clk     (clk),
      .we      (bank_we[i]),
      .wr_row  (bank_wr_row[i]),
      .wr_data (bank_wr_data[i]),
      .re      (bank_re[i]),
      .rd_row  (bank_rd_row),
      .rd_data (bank_rd_data[i])
    );
  end

  read_path read_i (
    .clk          (clk),
    .reset        (reset),
    .read         (read),
    .rd_row       (rd_adr[row_bits-1:0]),
    .rd_pbank     (rd_pbank),
    .bank_rd_data (bank_rd_data),
    .bank_re      (bank_re),
    .bank_rd_row  (bank_rd_row),
    .rd_vld       (rd_vld),
    .rd_dout      (rd_dout)
  );

endmodule

// File: bench/mem_1r2w_assertions.sv
`timescale 1ns/1ps

// Checks on the bank map and the read pipeline.
module mem_1r2w_assertions import mem_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic [1:0] write,
  input logic       read,
  input logic       rd_vld,
  input logic       upd,
  input pbank_t     home_tbl [num_row][num_lbank],
  input pbank_t     free_tbl [num_row]
);

  int   fail_cnt = 0;
  logic map_ok;

  // Free bank of each row is none of its homes.
  always_comb begin
    map_ok = 1'b1;
    for (int r = 0; r < num_row; r++) begin
      for (int l = 0; l < num_lbank; l++) begin
        if (home_tbl[r][l] == free_tbl[r]) begin
          map_ok = 1'b0;
        end
      end
    end
  end

  ////////////////////////////////
  // Properties
  ////////////////////////////////

  free_bank_unused: assert property (@(posedge clk) disable iff (reset) map_ok)
    else begin
      fail_cnt++;
      $error("a row's free bank is also one of its home banks");
    end

  vld_after_read: assert property (@(posedge clk) disable iff (reset)
    read |-> ##2 rd_vld)
    else begin
      fail_cnt++;
      $error("rd_vld missing two cycles after read");
    end

  read_before_vld: assert property (@(posedge clk) disable iff (reset)
    rd_vld |-> $past(read, 2))
    else begin
      fail_cnt++;
      $error("rd_vld without a read two cycles before");
    end

  upd_on_dual_write: assert property (@(posedge clk) disable iff (reset)
    upd |-> &write)
    else begin
      fail_cnt++;
      $error("map update without both write strobes");
    end

endmodule

bind mem_1r2w_top mem_1r2w_assertions chk_i (
  .clk      (clk),
  .reset    (reset),
  .write    (write),
  .read     (read),
  .rd_vld   (rd_vld),
  .upd      (upd),
  .home_tbl (map_i.home_tbl),
  .free_tbl (map_i.free_tbl)
);

// File: bench/mem_1r2w_tb.sv
`timescale 1ns/1ps

module mem_1r2w_tb import mem_pkg::*; ();

  localparam int clk_period = 20;
  localparam int seed = 66724;
  localparam int num_rows = 16; // Rows per logical bank.
  localparam int num_lbanks = 4;
  localparam int n_conflict = 100;
  localparam int n_random = 2000;
  localparam int drain = read_latency + 8; // Idle cycles at the end of a test, at most.
  localparam int total_cycles = 8 + 64 * 2 + 32 * 3 + n_conflict * 3 + 16 * 2
                              + 8 * 2 + 16 + n_random + 6 * drain;
  localparam longint timeout_ns = 2 * longint'(total_cycles) * clk_period;

  logic       clk;
  logic       reset;
  logic [1:0] write;
  addr_t      wr_adr0;
  addr_t      wr_adr1;
  data_t      din0;
  data_t      din1;
  logic       read;
  addr_t      rd_adr;
  logic       rd_vld;
  data_t      rd_dout;

  data_t ref_mem [2**$bits(addr_t)]; // Reference copy of the memory.
  data_t exp_q [$];
  addr_t adr_q [$];
  logic [read_latency-1:0] read_hist = '0;
  int    err_cnt = 0;
  int    chk_cnt = 0;
  int    test_no = 0;
  int    err_mark = 0;

  mem_1r2w_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .write   (write),
    .wr_adr0 (wr_adr0),
    .wr_adr1 (wr_adr1),
    .din0    (din0),
    .din1    (din1),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////
  // Reference model
  ////////////////////////////////

  // Returns the read word as it was before this cycle's writes.
  function automatic data_t model_cycle(logic [1:0] wr, addr_t a0, addr_t a1,
                                        data_t d0, data_t d1, addr_t ra);
    data_t old;
    old = ref_mem[ra];
    if (wr[0]) ref_mem[a0] = d0;
    if (wr[1]) ref_mem[a1] = d1; // Port 1 wins on the same address.
    return old;
  endfunction

  function automatic addr_t make_adr(int lbank, int row);
    return addr_t'(lbank * num_rows + row);
  endfunction

  ////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////

  task automatic drive_cycle(input logic [1:0] wr, input addr_t a0, input addr_t a1,
                             input data_t d0, input data_t d1,
                             input logic rd, input addr_t ra);
    data_t exp;
    @(posedge clk);
    write <= wr;
    wr_adr0 <= a0;
    wr_adr1 <= a1;
    din0 <= d0;
    din1 <= d1;
    read <= rd;
    rd_adr <= ra;
    exp = model_cycle(wr, a0, a1, d0, d1, ra);
    if (rd) begin
      exp_q.push_back(exp);
      adr_q.push_back(ra);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(2'b00, '0, '0, '0, '0, 1'b0, '0);
  endtask

  task automatic read_word(input addr_t a);
    drive_cycle(2'b00, '0, '0, '0, '0, 1'b1, a);
  endtask

  task automatic start_test();
    test_no++;
    err_mark = err_cnt;
  endtask

  // Waits for all reads of the test to return.
  task automatic finish_test(input string name);
    idle(1);
    while (exp_q.size() != 0) begin
      idle(1);
    end
    idle(read_latency);
    $display("test %0d %s: %0d errors", test_no, name, err_cnt - err_mark);
  endtask

  ////////////////////////////////
  // Tests
  ////////////////////////////////

  task automatic single_writes();
    start_test();
    for (int i = 0; i < 64; i++) begin
      if (i % 2 == 0) drive_cycle(2'b01, addr_t'(i), '0, data_t'($urandom), '0, 1'b0, '0);
      else drive_cycle(2'b10, '0, addr_t'(i), '0, data_t'($urandom), 1'b0, '0);
    end
    for (int i = 0; i < 64; i++) read_word(addr_t'(i));
    finish_test("single writes");
  endtask

  task automatic dual_writes();
    addr_t a0;
    addr_t a1;
    int    lb1;
    start_test();
    for (int i = 0; i < 32; i++) begin
      a0 = addr_t'($urandom);
      lb1 = (a0 / num_rows + 1 + $urandom_range(2)) % num_lbanks; // Another logical bank.
      a1 = make_adr(lb1, $urandom_range(num_rows - 1));
      drive_cycle(2'b11, a0, a1, data_t'($urandom), data_t'($urandom), 1'b0, '0);
      read_word(a0);
      read_word(a1);
    end
    finish_test("dual writes");
  endtask

  task automatic forced_conflicts();
    addr_t a0;
    addr_t a1;
    int    lb;
    start_test();
    for (int i = 0; i < n_conflict; i++) begin
      lb = $urandom_range(num_lbanks - 1);
      a0 = make_adr(lb, 3);
      a1 = make_adr(lb, 9);
      drive_cycle(2'b11, a0, a1, data_t'($urandom), data_t'($urandom), 1'b0, '0);
      read_word(a0);
      read_word(a1);
    end
    finish_test("forced conflicts");
  endtask

  task automatic same_address();
    addr_t a;
    start_test();
    for (int i = 0; i < 16; i++) begin
      a = addr_t'($urandom);
      drive_cycle(2'b11, a, a, data_t'($urandom), data_t'($urandom), 1'b0, '0);
      read_word(a);
    end
    finish_test("same address");
  endtask

  task automatic read_during_write();
    addr_t a;
    start_test();
    for (int i = 0; i < 8; i++) begin
      a = addr_t'($urandom);
      if (i % 2 == 0) drive_cycle(2'b01, a, '0, data_t'($urandom), '0, 1'b1, a);
      else drive_cycle(2'b10, '0, a, '0, data_t'($urandom), 1'b1, a);
      read_word(a); // New value now.
    end
    for (int i = 0; i < 16; i++) read_word(addr_t'($urandom));
    finish_test("read during write");
  endtask

  task automatic random_traffic();
    start_test();
    for (int i = 0; i < n_random; i++) begin
      drive_cycle(2'($urandom), addr_t'($urandom), addr_t'($urandom),
                  data_t'($urandom), data_t'($urandom), 1'($urandom), addr_t'($urandom));
    end
    finish_test("random traffic");
  endtask

  ////////////////////////////////
  // Main sequence
  ////////////////////////////////

  initial begin
    int unused;
    reset = 1'b1;
    write = 2'b00;
    wr_adr0 = '0;
    wr_adr1 = '0;
    din0 = '0;
    din1 = '0;
    read = 1'b0;
    rd_adr = '0;
    unused = $urandom(seed);
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    single_writes();
    dual_writes();
    forced_conflicts();
    same_address();
    read_during_write();
    random_traffic();
    $display("checks %0d, errors %0d, assertion failures %0d",
             chk_cnt, err_cnt, dut_i.chk_i.fail_cnt);
    if (err_cnt == 0 && dut_i.chk_i.fail_cnt == 0 && chk_cnt > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  ////////////////////////////////
  // Comparison
  ////////////////////////////////

  // Outputs are stable at the falling edge.
  always @(negedge clk) begin
    data_t exp;
    addr_t adr;
    if (reset === 1'b0) begin
      if (rd_vld !== read_hist[read_latency-1]) begin
        $display("ERR rd_vld got=%h exp=%h", rd_vld, read_hist[read_latency-1]);
        err_cnt++;
        if (read_hist[read_latency-1] && exp_q.size() != 0) begin
          exp = exp_q.pop_front(); // Drop the lost read.
          adr = adr_q.pop_front();
        end
      end else if (rd_vld) begin
        if (exp_q.size() == 0) begin
          $display("read data returned with no read outstanding");
          err_cnt++;
        end else begin
          exp = exp_q.pop_front();
          adr = adr_q.pop_front();
          chk_cnt++;
          if (rd_dout !== exp) begin
            $display("ERR rd_dout adr=%h got=%h exp=%h", adr, rd_dout, exp);
            err_cnt++;
          end
        end
      end
    end
    read_hist <= {read_hist[read_latency-2:0], read};
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns with reads still pending", timeout_ns);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: all.f
src/mem_pkg.sv
src/bank_ram.sv
src/bank_map.sv
src/write_steer.sv
src/read_path.sv
src/mem_1r2w_top.sv
bench/mem_1r2w_assertions.sv
bench/mem_1r2w_tb.sv

// File: Bender.yml
package:
  name: mem_1r2w

sources:
  - files:
      - src/mem_pkg.sv
      - src/bank_ram.sv
      - src/bank_map.sv
      - src/write_steer.sv
      - src/read_path.sv
      - src/mem_1r2w_top.sv
  - target: test
    files:
      - bench/mem_1r2w_assertions.sv
      - bench/mem_1r2w_tb.sv

# Testbench top: mem_1r2w_tb; design top: mem_1r2w_top.
